// File: Makefile
# simulation of the video control shell with Verilator
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
LINT     = --lint-only -Wall
TOP      = tb_vid_ctrl
FILELIST = tb.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# pass only when the log holds the pass line
run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST OK" $(LOG)

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: host_cmd_decode.sv
// host command decoder: splits the word stream into a command and indexed writes
`timescale 1ns/10ps

`include "vid_settings.svh"

module host_cmd_decode (
	input  logic                clk_sys,
	input  logic                resetd,
	input  logic                i_io_sel,
	input  logic                i_io_strobe,
	input  vid_pkg::io_word_t   i_io_din,
	output logic                o_wr,
	output vid_pkg::cmd_e       o_cmd,
	output vid_pkg::word_idx_t  o_idx,
	output vid_pkg::io_word_t   o_data
);

	import vid_pkg::*;

	logic      has_cmd;
	cmd_e      cmd_q;
	word_idx_t cnt;

	//////////////////////////////////////////////////////////////////////
	// control: command flag, word counter, write strobe
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cnt     <= '0;
			o_wr    <= 1'b0;
		end else begin
			o_wr <= 1'b0;
			if (!i_io_sel) begin
				// select dropped, next word is a new command
				has_cmd <= 1'b0;
			end else if (i_io_strobe) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					cnt     <= '0;
				end else begin
					o_wr <= 1'b1;
					// index saturates, later words reuse the last one
					if (cnt != '1) begin
						cnt <= cnt + 1'b1;
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// payload: latched command and the outgoing write
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (i_io_sel && i_io_strobe) begin
			if (!has_cmd) begin
				// unknown codes pass through and match no register
				cmd_q <= cmd_e'(i_io_din[`VID_CMD_W-1:0]);
			end else begin
				o_cmd  <= cmd_q;
				o_idx  <= cnt;
				o_data <= i_io_din;
			end
		end
	end

endmodule

// File: sync_pol_fix.sv
// sync polarity fixer: measures high and low runs and outputs active-high sync
`timescale 1ns/10ps

`include "vid_settings.svh"

module sync_pol_fix (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync_raw,
	output logic o_sync
);

	logic                       s1, s2;
	logic [`VID_SYNC_CNT_W-1:0] cnt;
	logic [`VID_SYNC_CNT_W-1:0] high_len, low_len;
	logic                       high_seen, low_seen;
	logic                       pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1        <= 1'b0;
			s2        <= 1'b0;
			cnt       <= '0;
			high_len  <= '0;
			low_len   <= '0;
			high_seen <= 1'b0;
			low_seen  <= 1'b0;
			pol       <= 1'b0;
		end else begin
			s1 <= i_sync_raw;
			s2 <= s1;
			if (s1 != s2) begin
				cnt <= '0;
			end else if (cnt != '1) begin
				cnt <= cnt + 1'b1;
			end
			// rising edge ends a low run, falling edge a high run
			if (s1 && !s2) begin
				low_len  <= cnt;
				low_seen <= 1'b1;
			end
			if (!s1 && s2) begin
				high_len  <= cnt;
				high_seen <= 1'b1;
			end
			// longer high run means the sync pulse is the low part
			if (high_seen && low_seen) begin
				pol <= high_len > low_len;
			end
		end
	end

	assign o_sync = i_sync_raw ^ pol;

endmodule

// File: tb.f
+incdir+.
vid_pkg.sv
host_cmd_decode.sv
vid_cfg_regs.sv
win_calc.sv
sync_pol_fix.sv
vid_ctrl_top.sv
tb_vid_ctrl.sv

// File: tb_vid_ctrl.sv
// video control shell testbench with random host traffic and a reference model
`timescale 1ns/10ps

`include "vid_settings.svh"

module tb_vid_ctrl;

	import vid_pkg::*;

	// 300 host transactions of up to about 30 cycles and a sync phase below 500 cycles
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int NUM_TRANS      = 300;

	logic                  clk_sys;
	logic                  resetd;
	logic                  i_io_sel;
	logic                  i_io_strobe;
	io_word_t              i_io_din;
	aspect_t               i_arx;
	aspect_t               i_ary;
	logic [`VID_LED_W-1:0] i_led_status;
	logic                  i_hs_raw;
	logic                  i_vs_raw;
	io_word_t              o_cfg;
	logic [`VID_VOL_W-1:0] o_vol_att;
	logic [`VID_LED_W-1:0] o_led;
	coord_t                o_hmin, o_hmax, o_vmin, o_vmax;
	logic                  o_win_valid;
	logic                  o_hs, o_vs;

	integer   seed;
	int       cycle = 0;
	int       valid_cnt = 0;
	int       last_valid = 0;
	int       first_cycle;
	io_word_t words [0:7];

	// reference model of the registers and the expected window
	io_word_t              m_cfg;
	logic [`VID_VOL_W-1:0] m_vol;
	logic [`VID_LED_W-1:0] m_ovr, m_state;
	coord_t                m_width, m_height, m_vset, m_hset;
	logic                  m_fs;
	coord_t                m_hmin, m_hmax, m_vmin, m_vmax;

	vid_ctrl_top u_vid_ctrl_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// cycle k is the interval after the k-th rising edge
	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
		if (cycle == TIMEOUT_CYCLES) begin
			fail_run("timeout, the run did not finish within the cycle limit");
		end
	end

	always @(negedge clk_sys) begin
		if (o_win_valid === 1'b1) begin
			valid_cnt  <= valid_cnt + 1;
			last_valid <= cycle;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("error at %0t: %s", $time, why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// host state bit on overridden leds and board status bit on the others
	function automatic logic [`VID_LED_W-1:0] expected_leds(
			input logic [`VID_LED_W-1:0] status);
		logic [`VID_LED_W-1:0] leds;
		int b;
		for (b = 0; b < `VID_LED_W; b++) begin
			if (m_ovr[b]) begin
				leds[b] = m_state[b];
			end else begin
				leds[b] = status[b];
			end
		end
		return leds;
	endfunction

	task automatic check_outputs();
		check_eq(o_cfg, m_cfg, "o_cfg");
		check_eq(o_vol_att, m_vol, "o_vol_att");
		check_eq(o_led, expected_leds(i_led_status), "o_led");
		check_eq(o_hmin, m_hmin, "o_hmin");
		check_eq(o_hmax, m_hmax, "o_hmax");
		check_eq(o_vmin, m_vmin, "o_vmin");
		check_eq(o_vmax, m_vmax, "o_vmax");
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	task automatic update_model(input logic [7:0] code, input int idx, input io_word_t d,
			output logic geo);
		geo = 1'b0;
		case (code)
			`VID_CMD_CFG: m_cfg = d;
			`VID_CMD_VOL: m_vol = d[`VID_VOL_W-1:0];
			`VID_CMD_LED: begin
				m_ovr   = d[15:8];
				m_state = d[7:0];
			end
			`VID_CMD_TIMING: begin
				// only words 0 and 4 are kept, and only a change recalculates
				if (idx == 0 && d[`VID_COORD_W-1:0] != m_width) begin
					m_width = d[`VID_COORD_W-1:0];
					geo     = 1'b1;
				end
				if (idx == 4 && d[`VID_COORD_W-1:0] != m_height) begin
					m_height = d[`VID_COORD_W-1:0];
					geo      = 1'b1;
				end
			end
			`VID_CMD_VSET: begin
				m_vset = d[`VID_COORD_W-1:0];
				geo    = 1'b1;
			end
			`VID_CMD_HSET: begin
				m_fs   = d[15];
				m_hset = d[`VID_COORD_W-1:0];
				geo    = 1'b1;
			end
			default: ;
		endcase
	endtask

	// clamp, aspect scale, minimum, centre
	task automatic expect_window();
		int eff_w, eff_h, cand_w, cand_h, win_w, win_h;
		eff_h = (m_vset != 0 && m_vset < m_height) ? m_vset : m_height;
		eff_w = (m_hset != 0 && m_hset < m_width) ? m_hset : m_width;
		if (i_arx != 0 && i_ary != 0 && !m_fs) begin
			cand_w = eff_h * i_arx / i_ary;
			cand_h = eff_w * i_ary / i_arx;
		end else begin
			cand_w = eff_w;
			cand_h = eff_h;
		end
		win_w  = (cand_w < eff_w) ? cand_w : eff_w;
		win_h  = (cand_h < eff_h) ? cand_h : eff_h;
		m_hmin = coord_t'((m_width - win_w) >> 1);
		m_hmax = coord_t'(m_hmin + win_w - 1);
		m_vmin = coord_t'((m_height - win_h) >> 1);
		m_vmax = coord_t'(m_vmin + win_h - 1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	function automatic aspect_t rand_aspect();
		int r;
		r = $random(seed);
		// zero now and then to cover the no-aspect path
		return (r[2:0] == 3'd0) ? aspect_t'(0) : aspect_t'(r[15:8]);
	endfunction

	// command word and data words on back-to-back strobes, then select drops
	task automatic send_cmd(input logic [7:0] code, input int nwords);
		int i;
		@(posedge clk_sys);
		i_io_sel <= 1'b1;
		@(posedge clk_sys);
		i_io_strobe <= 1'b1;
		i_io_din    <= {8'h00, code};
		for (i = 0; i < nwords; i++) begin
			@(posedge clk_sys);
			if (i == 0) begin
				first_cycle = cycle + 1;
			end
			i_io_din <= words[i];
		end
		@(posedge clk_sys);
		i_io_strobe <= 1'b0;
		i_io_sel    <= 1'b0;
		i_io_din    <= '0;
	endtask

	task automatic wait_window(input int vc0, input int exp_cycle);
		int n;
		n = 0;
		while (valid_cnt == vc0 && n < 40) begin
			@(posedge clk_sys);
			n++;
		end
		if (valid_cnt == vc0) begin
			fail_run("no window valid pulse within 40 cycles");
		end
		if (exp_cycle >= 0) begin
			check_eq(last_valid, exp_cycle, "window valid cycle");
		end
		expect_window();
		@(negedge clk_sys);
		check_outputs();
		repeat (10) @(posedge clk_sys);
		check_eq(valid_cnt, vc0 + 1, "window valid pulses");
	endtask

	// short sync pulse with a random period is checked after two full periods
	task automatic sync_phase(input logic act_high);
		int hper, vper, hpw, vpw, c;
		logic exp_h, exp_v;
		hper = 20 + {$random(seed)} % 41;
		vper = 20 + {$random(seed)} % 41;
		hpw  = 2 + {$random(seed)} % 4;
		vpw  = 2 + {$random(seed)} % 4;
		for (c = 0; c < 4 * ((hper > vper) ? hper : vper); c++) begin
			exp_h = (c % hper) < hpw;
			exp_v = (c % vper) < vpw;
			@(posedge clk_sys);
			i_hs_raw <= exp_h ^ !act_high;
			i_vs_raw <= exp_v ^ !act_high;
			@(negedge clk_sys);
			if (c >= 2 * hper) begin
				check_eq(o_hs, exp_h, "o_hs");
			end
			if (c >= 2 * vper) begin
				check_eq(o_vs, exp_v, "o_vs");
			end
		end
	endtask

	initial begin
		int t, kind, nwords, i, vc0, geo_cycle;
		logic geo, g;
		logic [7:0] code;
		seed         = 38727;
		resetd       = 1'b1;
		i_io_sel     = 1'b0;
		i_io_strobe  = 1'b0;
		i_io_din     = '0;
		i_arx        = rand_aspect();
		i_ary        = rand_aspect();
		i_led_status = 8'($random(seed));
		i_hs_raw     = 1'b0;
		i_vs_raw     = 1'b0;
		m_cfg        = '0;
		m_vol        = '0;
		m_ovr        = '0;
		m_state      = '0;
		m_width      = coord_t'(`VID_DEF_WIDTH);
		m_height     = coord_t'(`VID_DEF_HEIGHT);
		m_vset       = '0;
		m_hset       = '0;
		m_fs         = 1'b0;
		repeat (8) @(posedge clk_sys);
		resetd <= 1'b0;
		// start-up recalc with the default 1080p size
		wait_window(0, -1);

		for (t = 0; t < NUM_TRANS; t++) begin
			kind = {$random(seed)} % 7;
			vc0  = valid_cnt;
			@(posedge clk_sys);
			i_led_status <= 8'($random(seed));
			if (kind >= 3 && kind <= 5) begin
				i_arx <= rand_aspect();
				i_ary <= rand_aspect();
			end
			case (kind)
				0: code = `VID_CMD_CFG;
				1: code = `VID_CMD_VOL;
				2: code = `VID_CMD_LED;
				3: code = `VID_CMD_TIMING;
				4: code = `VID_CMD_VSET;
				5: code = `VID_CMD_HSET;
				default: code = {2'b01, 6'($random(seed))};
			endcase
			nwords = (kind == 3) ? 8 : (kind == 6) ? 1 + {$random(seed)} % 8 : 1;
			for (i = 0; i < nwords; i++) begin
				words[i] = io_word_t'($random(seed));
			end
			if (kind == 6) begin
				// stray strobe with select low must be ignored
				@(posedge clk_sys);
				i_io_strobe <= 1'b1;
				i_io_din    <= {8'h00, `VID_CMD_CFG};
				@(posedge clk_sys);
				i_io_strobe <= 1'b0;
			end
			send_cmd(code, nwords);
			// one cycle after the last strobe nothing has landed yet
			@(negedge clk_sys);
			check_outputs();
			geo = 1'b0;
			geo_cycle = 0;
			for (i = 0; i < nwords; i++) begin
				update_model(code, i, words[i], g);
				if (g) begin
					geo       = 1'b1;
					geo_cycle = first_cycle + i;
				end
			end
			@(negedge clk_sys);
			check_outputs();
			if (geo) begin
				wait_window(vc0, geo_cycle + 11);
			end else begin
				repeat (14) @(posedge clk_sys);
				check_eq(valid_cnt, vc0, "window valid without a geometry change");
			end
		end

		sync_phase(1'b0);
		sync_phase(1'b1);

		$display("TEST OK");
		$finish;
	end

endmodule

// File: vid_cfg_regs.sv
// configuration registers of the video shell with led override and recalc strobe
`timescale 1ns/10ps

`include "vid_settings.svh"

module vid_cfg_regs (
	input  logic                   clk_sys,
	input  logic                   resetd,
	input  logic                   i_wr,
	input  vid_pkg::cmd_e          i_cmd,
	input  vid_pkg::word_idx_t     i_idx,
	input  vid_pkg::io_word_t      i_data,
	input  logic [`VID_LED_W-1:0]  i_led_status,
	output vid_pkg::io_word_t      o_cfg,
	output logic [`VID_VOL_W-1:0]  o_vol_att,
	output logic [`VID_LED_W-1:0]  o_led,
	output vid_pkg::coord_t        o_width,
	output vid_pkg::coord_t        o_height,
	output vid_pkg::coord_t        o_vset,
	output vid_pkg::coord_t        o_hset,
	output logic                   o_freescale,
	output logic                   o_recalc
);

	import vid_pkg::*;

	// timing command word positions that survive
	localparam word_idx_t IDX_WIDTH  = word_idx_t'(0);
	localparam word_idx_t IDX_HEIGHT = word_idx_t'(4);

	logic [`VID_LED_W-1:0] led_ovr;
	logic [`VID_LED_W-1:0] led_state;
	coord_t                wr_coord;
	logic                  geo_wr;
	logic                  recalc_pend;

	assign wr_coord = i_data[`VID_COORD_W-1:0];

	//////////////////////////////////////////////////////////////////////
	// geometry change detect
	//////////////////////////////////////////////////////////////////////

	// timing words only count when the value really changes
	always_comb begin
		geo_wr = 1'b0;
		if (i_wr) begin
			case (i_cmd)
				CMD_TIMING: begin
					geo_wr = ((i_idx == IDX_WIDTH) && (wr_coord != o_width)) ||
						((i_idx == IDX_HEIGHT) && (wr_coord != o_height));
				end
				CMD_VSET, CMD_HSET: geo_wr = 1'b1;
				default: geo_wr = 1'b0;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// register writes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_cfg       <= '0;
			o_vol_att   <= '0;
			led_ovr     <= '0;
			led_state   <= '0;
			o_width     <= coord_t'(`VID_DEF_WIDTH);
			o_height    <= coord_t'(`VID_DEF_HEIGHT);
			o_vset      <= '0;
			o_hset      <= '0;
			o_freescale <= 1'b0;
			// pending at reset gives the one start-up recalc
			recalc_pend <= 1'b1;
			o_recalc    <= 1'b0;
		end else begin
			recalc_pend <= geo_wr;
			o_recalc    <= recalc_pend;
			if (i_wr) begin
				case (i_cmd)
					CMD_CFG: o_cfg <= i_data;
					CMD_TIMING: begin
						if (i_idx == IDX_WIDTH) begin
							o_width <= wr_coord;
						end
						if (i_idx == IDX_HEIGHT) begin
							o_height <= wr_coord;
						end
					end
					CMD_LED: begin
						led_ovr   <= i_data[8 +: `VID_LED_W];
						led_state <= i_data[0 +: `VID_LED_W];
					end
					CMD_VOL:  o_vol_att <= i_data[`VID_VOL_W-1:0];
					CMD_VSET: o_vset <= wr_coord;
					CMD_HSET: begin
						o_freescale <= i_data[`VID_IO_W-1];
						o_hset      <= wr_coord;
					end
					default: ;
				endcase
			end
		end
	end

	// per-bit led mux, host state wins where overridden
	assign o_led = (led_ovr & led_state) | (~led_ovr & i_led_status);

endmodule

// File: vid_ctrl_top.sv
// video control shell top: host decode, config registers, window calc, sync fixers
`timescale 1ns/10ps

`include "vid_settings.svh"

module vid_ctrl_top (
	input  logic                   clk_sys,
	input  logic                   resetd,
	input  logic                   i_io_sel,
	input  logic                   i_io_strobe,
	input  vid_pkg::io_word_t      i_io_din,
	input  vid_pkg::aspect_t       i_arx,
	input  vid_pkg::aspect_t       i_ary,
	input  logic [`VID_LED_W-1:0]  i_led_status,
	input  logic                   i_hs_raw,
	input  logic                   i_vs_raw,
	output vid_pkg::io_word_t      o_cfg,
	output logic [`VID_VOL_W-1:0]  o_vol_att,
	output logic [`VID_LED_W-1:0]  o_led,
	output vid_pkg::coord_t        o_hmin,
	output vid_pkg::coord_t        o_hmax,
	output vid_pkg::coord_t        o_vmin,
	output vid_pkg::coord_t        o_vmax,
	output logic                   o_win_valid,
	output logic                   o_hs,
	output logic                   o_vs
);

	import vid_pkg::*;

	logic      wr;
	cmd_e      cmd;
	word_idx_t idx;
	io_word_t  data;
	coord_t    width, height, vset, hset;
	logic      freescale;
	logic      recalc;

	//////////////////////////////////////////////////////////////////////
	// command path: decode, execute, result
	//////////////////////////////////////////////////////////////////////

	host_cmd_decode u_host_cmd_decode (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_sel    (i_io_sel),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_wr        (wr),
		.o_cmd       (cmd),
		.o_idx       (idx),
		.o_data      (data)
	);

	vid_cfg_regs u_vid_cfg_regs (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_wr         (wr),
		.i_cmd        (cmd),
		.i_idx        (idx),
		.i_data       (data),
		.i_led_status (i_led_status),
		.o_cfg        (o_cfg),
		.o_vol_att    (o_vol_att),
		.o_led        (o_led),
		.o_width      (width),
		.o_height     (height),
		.o_vset       (vset),
		.o_hset       (hset),
		.o_freescale  (freescale),
		.o_recalc     (recalc)
	);

	win_calc u_win_calc (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_start     (recalc),
		.i_width     (width),
		.i_height    (height),
		.i_vset      (vset),
		.i_hset      (hset),
		.i_freescale (freescale),
		.i_arx       (i_arx),
		.i_ary       (i_ary),
		.o_hmin      (o_hmin),
		.o_hmax      (o_hmax),
		.o_vmin      (o_vmin),
		.o_vmax      (o_vmax),
		.o_win_valid (o_win_valid)
	);

	// one fixer per sync line
	sync_pol_fix u_hs_fix (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_sync_raw (i_hs_raw),
		.o_sync     (o_hs)
	);

	sync_pol_fix u_vs_fix (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_sync_raw (i_vs_raw),
		.o_sync     (o_vs)
	);

endmodule

// File: vid_pkg.sv
// shared types of the video control shell: coordinates, host words, commands
package vid_pkg;

`include "vid_settings.svh"

	// one pixel or line position
	typedef logic [`VID_COORD_W-1:0] coord_t;

	// raw word from the host channel
	typedef logic [`VID_IO_W-1:0] io_word_t;

	// aspect ratio term from the core
	typedef logic [`VID_ASPECT_W-1:0] aspect_t;

	// index of a data word after the command byte
	typedef logic [`VID_IDX_W-1:0] word_idx_t;

	// command byte, codes outside this list are ignored
	typedef enum logic [`VID_CMD_W-1:0] {
		CMD_CFG    = `VID_CMD_CFG,
		CMD_TIMING = `VID_CMD_TIMING,
		CMD_LED    = `VID_CMD_LED,
		CMD_VOL    = `VID_CMD_VOL,
		CMD_VSET   = `VID_CMD_VSET,
		CMD_HSET   = `VID_CMD_HSET
	} cmd_e;

endpackage

// File: vid_settings.svh
// video shell settings: widths, command codes and reset defaults
`ifndef VID_SETTINGS_SVH
`define VID_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// data path widths
//////////////////////////////////////////////////////////////////////

// pixel or line coordinate
`define VID_COORD_W 12

// host word from the command channel
`define VID_IO_W 16

// one aspect ratio term, arx or ary
`define VID_ASPECT_W 8

// audio attenuation field
`define VID_VOL_W 5

// board leds
`define VID_LED_W 8

// sync run length counters
`define VID_SYNC_CNT_W 16

// command byte and data word index
`define VID_CMD_W 8
`define VID_IDX_W 4

//////////////////////////////////////////////////////////////////////
// reset defaults, 1080p active area
//////////////////////////////////////////////////////////////////////

`define VID_DEF_WIDTH  1920
`define VID_DEF_HEIGHT 1080

//////////////////////////////////////////////////////////////////////
// host command codes
//////////////////////////////////////////////////////////////////////

`define VID_CMD_CFG    8'h01
`define VID_CMD_TIMING 8'h20
`define VID_CMD_LED    8'h25
`define VID_CMD_VOL    8'h26
`define VID_CMD_VSET   8'h27
`define VID_CMD_HSET   8'h37

`endif

// File: win_calc.sv
// display window calculator: aspect-corrected, centred window from the active size
`timescale 1ns/10ps

`include "vid_settings.svh"

module win_calc (
	input  logic             clk_sys,
	input  logic             resetd,
	input  logic             i_start,
	input  vid_pkg::coord_t  i_width,
	input  vid_pkg::coord_t  i_height,
	input  vid_pkg::coord_t  i_vset,
	input  vid_pkg::coord_t  i_hset,
	input  logic             i_freescale,
	input  vid_pkg::aspect_t i_arx,
	input  vid_pkg::aspect_t i_ary,
	output vid_pkg::coord_t  o_hmin,
	output vid_pkg::coord_t  o_hmax,
	output vid_pkg::coord_t  o_vmin,
	output vid_pkg::coord_t  o_vmax,
	output logic             o_win_valid
);

	import vid_pkg::*;

	localparam int PROD_W = `VID_COORD_W + `VID_ASPECT_W;

	logic [2:0]        state;
	coord_t            width_q, height_q, vset_q, hset_q;
	logic              fs_q;
	aspect_t           arx_q, ary_q;
	logic              use_ar;
	coord_t            eff_w, eff_h;
	logic [PROD_W-1:0] wcalc, hcalc;
	coord_t            vid_w, vid_h;
	coord_t            hoff, voff, hmax_r, vmax_r;

	// state 0 idle, 1..7 busy, valid follows state 7
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state       <= 3'd0;
			o_win_valid <= 1'b0;
		end else begin
			o_win_valid <= 1'b0;
			if (i_start) begin
				state <= 3'd1;
			end else if (state != 3'd0) begin
				state <= state + 3'd1;
				if (state == 3'd7) begin
					o_win_valid <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// data path, one step per state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			width_q  <= i_width;
			height_q <= i_height;
			vset_q   <= i_vset;
			hset_q   <= i_hset;
			fs_q     <= i_freescale;
			arx_q    <= i_arx;
			ary_q    <= i_ary;
		end else begin
			case (state)
				3'd1: begin
					// clamp to the size limits
					eff_h  <= (vset_q != '0 && vset_q < height_q) ? vset_q : height_q;
					eff_w  <= (hset_q != '0 && hset_q < width_q) ? hset_q : width_q;
					use_ar <= (arx_q != '0) && (ary_q != '0) && !fs_q;
				end
				3'd2: begin
					if (use_ar) begin
						wcalc <= eff_h * arx_q;
						hcalc <= eff_w * ary_q;
					end else begin
						wcalc <= PROD_W'(eff_w);
						hcalc <= PROD_W'(eff_h);
					end
				end
				3'd3: begin
					if (use_ar) begin
						wcalc <= wcalc / ary_q;
						hcalc <= hcalc / arx_q;
					end
				end
				3'd4: begin
					vid_w <= (wcalc > PROD_W'(eff_w)) ? eff_w : wcalc[`VID_COORD_W-1:0];
					vid_h <= (hcalc > PROD_W'(eff_h)) ? eff_h : hcalc[`VID_COORD_W-1:0];
				end
				3'd5: begin
					// centre inside the full active area
					hoff <= (width_q - vid_w) >> 1;
					voff <= (height_q - vid_h) >> 1;
				end
				3'd6: begin
					hmax_r <= hoff + vid_w - 1'b1;
					vmax_r <= voff + vid_h - 1'b1;
				end
				3'd7: begin
					o_hmin <= hoff;
					o_hmax <= hmax_r;
					o_vmin <= voff;
					o_vmax <= vmax_r;
				end
				default: ;
			endcase
		end
	end

endmodule
